// File: design/center_of_mass.sv
`timescale 1ns/1ps
`default_nettype none
`include "vision_defines.svh"

module center_of_mass (
  input  wire                clk_pixel,
  input  wire                recent_reset,
  input  wire                mask_i,
  input  wire                valid_i,
  input  wire video_pkg::hcount_t hcount_i,
  input  wire video_pkg::vcount_t vcount_i,
  input  wire                eof_i, // raw, straight from the input beat
  output video_pkg::hcount_t com_x_o,
  output video_pkg::vcount_t com_y_o,
  output logic               com_valid_o
);
  import video_pkg::*;
  import ctrl_pkg::*;

  localparam int SUM_W   = `VISION_SUM_W;
  localparam int EOF_DLY = `VISION_PIPE_LAT - 1; // mask path depth
  localparam int CNT_W   = $clog2(SUM_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SUM_W - 1);

  // one restoring step, returns {remainder, quotient}
  function automatic logic [2*SUM_W-1:0] div_step(input sum_t rem, input sum_t quo,
                                                  input sum_t den);
    logic [SUM_W:0] sh;
    logic [SUM_W:0] dif;
    sh  = {rem, quo[SUM_W-1]}; // bring down next dividend bit
    dif = sh - {1'b0, den};
    if (sh >= {1'b0, den}) return {dif[SUM_W-1:0], quo[SUM_W-2:0], 1'b1};
    else                   return {sh[SUM_W-1:0], quo[SUM_W-2:0], 1'b0};
  endfunction

  logic [EOF_DLY-1:0] eof_q;
  logic               eof_al; // eof lined up with mask_i
  logic               hit;
  logic               start;
  sum_t               sum_x, sum_y, cnt;
  sum_t               tot_x, tot_y, tot_cnt; // running totals incl. this beat
  sum_t               rx, ry, qx, qy, den;
  logic [2*SUM_W-1:0] step_x, step_y;
  logic [CNT_W-1:0]   bit_cnt;
  div_state_e         state;

  assign eof_al  = eof_q[EOF_DLY-1];
  assign hit     = valid_i && mask_i;
  assign tot_x   = sum_x + (hit ? sum_t'(hcount_i) : '0);
  assign tot_y   = sum_y + (hit ? sum_t'(vcount_i) : '0);
  assign tot_cnt = cnt + sum_t'(hit);
  // a busy divider or an empty frame skips this eof
  assign start   = eof_al && (state == IDLE) && (tot_cnt != '0);
  assign step_x  = div_step(rx, qx, den);
  assign step_y  = div_step(ry, qy, den);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      eof_q       <= '0;
      sum_x       <= '0;
      sum_y       <= '0;
      cnt         <= '0;
      state       <= IDLE;
      bit_cnt     <= '0;
      com_x_o     <= '0;
      com_y_o     <= '0;
      com_valid_o <= 1'b0;
    end else begin
      eof_q       <= {eof_q[EOF_DLY-2:0], eof_i};
      com_valid_o <= 1'b0;
      if (eof_al) begin // totals handed off or dropped, new frame starts clean
        sum_x <= '0;
        sum_y <= '0;
        cnt   <= '0;
      end else begin
        sum_x <= tot_x;
        sum_y <= tot_y;
        cnt   <= tot_cnt;
      end
      case (state)
        IDLE: begin
          if (start) begin
            state   <= DIVIDE;
            bit_cnt <= LAST_BIT; // one quotient bit per cycle, msb first
          end
        end
        DIVIDE: begin
          if (bit_cnt == '0) begin
            state       <= IDLE;
            com_x_o     <= step_x[$bits(hcount_t)-1:0]; // mean < hres, upper bits zero
            com_y_o     <= step_y[$bits(vcount_t)-1:0];
            com_valid_o <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // divider datapath, x and y share the count as divisor
  always_ff @(posedge clk_pixel) begin
    if (start) begin
      qx  <= tot_x;
      qy  <= tot_y;
      den <= tot_cnt;
      rx  <= '0;
      ry  <= '0;
    end else if (state == DIVIDE) begin
      {rx, qx} <= step_x;
      {ry, qy} <= step_y;
    end
  end

  a_no_zero_div : assert property (@(posedge clk_pixel) disable iff (recent_reset)
    (state == IDLE) ##1 (state == DIVIDE) |-> (den != '0))
    else $error("divider started with a zero pixel count");

endmodule

`default_nettype wire

// File: design/color_stage.sv
`timescale 1ns/1ps
`default_nettype none

module color_stage (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  wire video_pkg::pix_beat_t pix_i,
  output video_pkg::out_beat_t beat_o
);
  import video_pkg::*;

  out_beat_t beat_s1;

  // stage 1 widens the pixel, stage 2 only delays to match mask_stage
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      beat_s1 <= '0;
      beat_o  <= '0;
    end else begin
      beat_s1.valid  <= pix_i.valid;
      beat_s1.hcount <= pix_i.hcount;
      beat_s1.vcount <= pix_i.vcount;
      beat_s1.pixel  <= expand565(pix_i.pixel); // zero padded 888
      beat_o         <= beat_s1;
    end
  end

endmodule

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // channel fed to the thresholder
  typedef enum logic [1:0] {
    RED   = 2'd0,
    GREEN = 2'd1,
    BLUE  = 2'd2,
    LUMA  = 2'd3 // (r + 2g + b) / 4
  } channel_e;

  // background drawn under the crosshair
  typedef enum logic [1:0] {
    NORMAL  = 2'd0, // camera pixel
    GRAY    = 2'd1, // selected channel on r, g and b
    MASK    = 2'd2, // white on mask, black off mask
    MAGENTA = 2'd3  // magenta on mask, camera pixel elsewhere
  } bg_mode_e;

  typedef struct packed {
    channel_e          channel;
    video_pkg::chan8_t lower; // inclusive
    video_pkg::chan8_t upper; // inclusive
    bg_mode_e          bg_mode;
    logic              crosshair;
  } cfg_t;

  typedef enum logic {IDLE, DIVIDE} div_state_e; // centre of mass divider

endpackage

`default_nettype wire

// File: design/mask_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mask_stage (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  wire video_pkg::pix_beat_t pix_i,
  input  wire ctrl_pkg::cfg_t cfg_i,
  output logic                mask_o,
  output video_pkg::chan8_t   chan_o,
  output logic                valid_o,
  output video_pkg::hcount_t  hcount_o,
  output video_pkg::vcount_t  vcount_o
);
  import video_pkg::*;
  import ctrl_pkg::*;

  rgb888_t    rgb;
  logic [9:0] luma_sum; // r + 2g + b peaks at 1020
  chan8_t     sel;

  logic    valid_s1;
  hcount_t hcount_s1;
  vcount_t vcount_s1;
  chan8_t  chan_s1;
  chan8_t  lower_s1, upper_s1; // bounds travel with the beat

  assign rgb      = expand565(pix_i.pixel);
  assign luma_sum = 10'(rgb[23:16]) + {1'b0, rgb[15:8], 1'b0} + 10'(rgb[7:0]);

  always_comb begin
    unique case (cfg_i.channel)
      RED:   sel = rgb[23:16];
      GREEN: sel = rgb[15:8];
      BLUE:  sel = rgb[7:0];
      LUMA:  sel = luma_sum[9:2]; // divide by 4
    endcase
  end

  // stage 1, channel pick
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) valid_s1 <= 1'b0;
    else              valid_s1 <= pix_i.valid;
  end

  always_ff @(posedge clk_pixel) begin
    hcount_s1 <= pix_i.hcount;
    vcount_s1 <= pix_i.vcount;
    chan_s1   <= sel;
    lower_s1  <= cfg_i.lower;
    upper_s1  <= cfg_i.upper;
  end

  // stage 2, inclusive window compare
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      valid_o <= 1'b0;
      mask_o  <= 1'b0;
    end else begin
      valid_o <= valid_s1;
      mask_o  <= valid_s1 && (chan_s1 >= lower_s1) && (chan_s1 <= upper_s1);
    end
  end

  always_ff @(posedge clk_pixel) begin
    chan_o   <= chan_s1;
    hcount_o <= hcount_s1;
    vcount_o <= vcount_s1;
  end

  a_mask_valid : assert property (@(posedge clk_pixel) disable iff (recent_reset)
    mask_o |-> valid_o)
    else $error("mask set on an invalid beat");

endmodule

`default_nettype wire

// File: design/overlay_mux.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_mux (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  wire video_pkg::out_beat_t beat_i,
  input  wire                 mask_i,
  input  wire video_pkg::chan8_t chan_i,
  input  wire ctrl_pkg::cfg_t cfg_i,
  input  wire video_pkg::hcount_t com_x_i,
  input  wire video_pkg::vcount_t com_y_i,
  output video_pkg::out_beat_t out_o
);
  import video_pkg::*;
  import ctrl_pkg::*;

  localparam rgb888_t WHITE_RGB   = 24'hff_ff_ff;
  localparam rgb888_t BLACK_RGB   = 24'h00_00_00;
  localparam rgb888_t MAGENTA_RGB = 24'hff_00_ff;

  rgb888_t bg;
  rgb888_t pix;
  logic    on_cross;

  always_comb begin
    unique case (cfg_i.bg_mode)
      NORMAL:  bg = beat_i.pixel;
      GRAY:    bg = {chan_i, chan_i, chan_i};
      MASK:    bg = mask_i ? WHITE_RGB : BLACK_RGB;
      MAGENTA: bg = mask_i ? MAGENTA_RGB : beat_i.pixel;
    endcase
  end

  // full row and column through the centre
  assign on_cross = cfg_i.crosshair &&
                    ((beat_i.hcount == com_x_i) || (beat_i.vcount == com_y_i));
  assign pix      = on_cross ? WHITE_RGB : bg;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      out_o <= '0;
    end else begin
      out_o.valid  <= beat_i.valid;
      out_o.hcount <= beat_i.hcount;
      out_o.vcount <= beat_i.vcount;
      out_o.pixel  <= pix;
    end
  end

endmodule

`default_nettype wire

// File: design/video_pkg.sv
`default_nettype none
`include "vision_defines.svh"

package video_pkg;

  typedef logic [`VISION_HCOUNT_W-1:0] hcount_t; // 11 bits for 1280
  typedef logic [`VISION_VCOUNT_W-1:0] vcount_t; // 10 bits for 720
  typedef logic [15:0] rgb565_t;
  typedef logic [23:0] rgb888_t; // red in the top byte
  typedef logic [7:0] chan8_t; // one colour channel or luma
  typedef logic [`VISION_SUM_W-1:0] sum_t; // accumulators and counts

  // one pixel beat from the source, eof flags the last beat of a frame
  typedef struct packed {
    logic    valid;
    logic    eof;
    hcount_t hcount;
    vcount_t vcount;
    rgb565_t pixel;
  } pix_beat_t;

  typedef struct packed {
    logic    valid;
    hcount_t hcount;
    vcount_t vcount;
    rgb888_t pixel;
  } out_beat_t;

  // 565 to 888 by padding the low bits with zeros
  function automatic rgb888_t expand565(input rgb565_t p);
    return {p[15:11], 3'b0, p[10:5], 2'b0, p[4:0], 3'b0};
  endfunction

endpackage

`default_nettype wire

// File: design/vision_defines.svh
`ifndef VISION_DEFINES_SVH
`define VISION_DEFINES_SVH

// active picture size
`define VISION_HRES 1280
`define VISION_VRES 720

// bits needed to hold a position on each axis
`define VISION_HCOUNT_W $clog2(`VISION_HRES)
`define VISION_VCOUNT_W $clog2(`VISION_VRES)

// position sums and masked pixel count, 1280*720*1279 still fits
`define VISION_SUM_W 32

// wishbone word addresses
`define VISION_ADR_CHAN  3'd0 // channel select, bits 1:0
`define VISION_ADR_LOWER 3'd1 // lower threshold, bits 7:0
`define VISION_ADR_UPPER 3'd2 // upper threshold, bits 7:0
`define VISION_ADR_MODE  3'd3 // bg mode in 1:0, crosshair enable in bit 2
`define VISION_ADR_COM   3'd4 // read only, x in 10:0, y in 25:16

// input beat to output beat, in clk_pixel cycles
`define VISION_PIPE_LAT 3

`endif

// File: design/vision_top.sv
`timescale 1ns/1ps
`default_nettype none

module vision_top (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  wire                 wb_cyc_i,
  input  wire                 wb_stb_i,
  input  wire                 wb_we_i,
  input  wire [2:0]           wb_adr_i,
  input  wire [31:0]          wb_dat_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o,
  input  wire video_pkg::pix_beat_t pix_i,
  output video_pkg::out_beat_t out_o,
  output logic                com_valid_o
);
  import video_pkg::*;
  import ctrl_pkg::*;

  cfg_t      cfg;
  logic      mask, mask_valid; // mask path, 2 cycles behind pix_i
  chan8_t    chan;
  hcount_t   mask_hcount, com_x;
  vcount_t   mask_vcount, com_y;
  out_beat_t color_beat;

  wb_cfg_regs wb_cfg_regs_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .com_x_i(com_x), .com_y_i(com_y), .cfg_o(cfg));

  mask_stage mask_stage_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .pix_i(pix_i), .cfg_i(cfg),
    .mask_o(mask), .chan_o(chan), .valid_o(mask_valid),
    .hcount_o(mask_hcount), .vcount_o(mask_vcount));

  color_stage color_stage_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .pix_i(pix_i), .beat_o(color_beat));

  center_of_mass center_of_mass_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .mask_i(mask), .valid_i(mask_valid),
    .hcount_i(mask_hcount), .vcount_i(mask_vcount),
    .eof_i(pix_i.eof), // delayed inside to match the mask
    .com_x_o(com_x), .com_y_o(com_y), .com_valid_o(com_valid_o));

  overlay_mux overlay_mux_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .beat_i(color_beat), .mask_i(mask), .chan_i(chan), .cfg_i(cfg),
    .com_x_i(com_x), .com_y_i(com_y), .out_o(out_o));

endmodule

`default_nettype wire

// File: design/wb_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "vision_defines.svh"

module wb_cfg_regs (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  wire                 wb_cyc_i,
  input  wire                 wb_stb_i,
  input  wire                 wb_we_i,
  input  wire [2:0]           wb_adr_i,
  input  wire [31:0]          wb_dat_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o,
  input  wire video_pkg::hcount_t com_x_i,
  input  wire video_pkg::vcount_t com_y_i,
  output ctrl_pkg::cfg_t      cfg_o
);
  import ctrl_pkg::*;

  logic        req; // new access, ack not yet given
  logic [31:0] rdata;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  // unused bits read back as zero
  always_comb begin
    case (wb_adr_i)
      `VISION_ADR_CHAN:  rdata = 32'(cfg_o.channel);
      `VISION_ADR_LOWER: rdata = 32'(cfg_o.lower);
      `VISION_ADR_UPPER: rdata = 32'(cfg_o.upper);
      `VISION_ADR_MODE:  rdata = 32'({cfg_o.crosshair, cfg_o.bg_mode});
      `VISION_ADR_COM:   rdata = {6'b0, com_y_i, 5'b0, com_x_i};
      default:           rdata = 32'b0; // holes read zero
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      wb_ack_o <= 1'b0;
      cfg_o    <= '0;
    end else begin
      wb_ack_o <= req; // single cycle, req drops once ack is up
      if (req && wb_we_i) begin
        case (wb_adr_i)
          `VISION_ADR_CHAN:  cfg_o.channel <= channel_e'(wb_dat_i[1:0]);
          `VISION_ADR_LOWER: cfg_o.lower   <= wb_dat_i[7:0];
          `VISION_ADR_UPPER: cfg_o.upper   <= wb_dat_i[7:0];
          `VISION_ADR_MODE: begin
            cfg_o.bg_mode   <= bg_mode_e'(wb_dat_i[1:0]);
            cfg_o.crosshair <= wb_dat_i[2];
          end
          default: ; // COM and holes are read only
        endcase
      end
    end
  end

  // read data captured with the ack edge, held while ack is high
  always_ff @(posedge clk_pixel) begin
    if (req) wb_dat_o <= rdata;
  end

  // a held strobe must not produce a second ack straight after the first
  a_ack_single : assert property (@(posedge clk_pixel) disable iff (recent_reset)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb ack high for two cycles");

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/video_pkg.sv
design/ctrl_pkg.sv
design/wb_cfg_regs.sv
design/mask_stage.sv
design/color_stage.sv
design/center_of_mass.sv
design/overlay_mux.sv
design/vision_top.sv
test/tb_vision_top.sv

// File: test/tb_vision_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "vision_defines.svh"

module tb_vision_top;
  import video_pkg::*;
  import ctrl_pkg::*;

  localparam int NUM_FRAMES  = 19;
  localparam int CYCLE_LIMIT = NUM_FRAMES * 512 + NUM_FRAMES * 64 + 400; // plus bus traffic

  logic        clk_pixel;
  logic        recent_reset;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  logic [2:0]  wb_adr;
  logic [31:0] wb_wdat, wb_rdat;
  pix_beat_t   pix;
  out_beat_t   out;
  logic        com_valid;

  int        cycles   = 0;
  int        bus_errs = 0;
  int        pix_errs = 0;
  int        com_errs = 0;
  out_beat_t exp_q[$]; // expected output beats, oldest first
  int        due_q[$]; // cycle on which each must appear

  // model copy of the configuration and of the centre
  channel_e m_chan;
  chan8_t   m_lo, m_hi;
  bg_mode_e m_mode;
  logic     m_cross;
  hcount_t  exp_x;
  vcount_t  exp_y;

  vision_top vision_top_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
    .pix_i(pix), .out_o(out), .com_valid_o(com_valid));

  initial begin
    clk_pixel = 1'b0;
    forever #2 clk_pixel = ~clk_pixel; // 4 ns period
  end

  always @(posedge clk_pixel) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // out_o settles well before the falling edge
  always @(negedge clk_pixel) begin
    out_beat_t e;
    int        due;
    if (out.valid) begin
      assert (exp_q.size() != 0) else begin
        $display("output beat at %0t with no input beat pending", $time);
        pix_errs++;
      end
      if (exp_q.size() != 0) begin
        e   = exp_q.pop_front();
        due = due_q.pop_front();
        assert (out === e && cycles == due) else begin
          $display("[ERROR] %0t got x=%0d y=%0d pix=%h cyc %0d, exp x=%0d y=%0d pix=%h cyc %0d",
                   $time, out.hcount, out.vcount, out.pixel, cycles,
                   e.hcount, e.vcount, e.pixel, due);
          pix_errs++;
        end
      end
    end else if (due_q.size() > 0) begin
      assert (cycles < due_q[0]) else begin
        $display("expected output beat at (%0d,%0d) never appeared", exp_q[0].hcount,
                 exp_q[0].vcount);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        pix_errs++;
      end
    end
  end

  task automatic tick(); // inputs change 0.5 ns after the edge
    @(posedge clk_pixel);
    #0.5;
  endtask

  function automatic rgb888_t widen(input rgb565_t p);
    return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
  endfunction

  function automatic chan8_t pick_chan(input rgb888_t c, input channel_e sel);
    int luma;
    luma = (int'(c[23:16]) + 2 * int'(c[15:8]) + int'(c[7:0])) / 4;
    case (sel)
      RED:     return c[23:16];
      GREEN:   return c[15:8];
      BLUE:    return c[7:0];
      default: return chan8_t'(luma);
    endcase
  endfunction

  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    int waited;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    waited  = 0;
    do begin
      tick();
      waited++;
    end while (!wb_ack && waited < 16);
    assert (wb_ack) else begin
      $display("no wishbone ack within 16 cycles, adr %0d", adr);
      bus_errs++;
    end
    assert (!wb_ack || waited == 1) else begin
      $display("[ERROR] %0t ack after %0d cycles, expected 1", $time, waited);
      bus_errs++;
    end
    rdat   = wb_rdat; // valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    tick();
    assert (!wb_ack) else begin
      $display("[ERROR] %0t ack high for a second cycle", $time);
      bus_errs++;
    end
  endtask

  task automatic check_read(input logic [2:0] adr, input logic [31:0] expv);
    logic [31:0] got;
    wb_access(1'b0, adr, 32'h0, got);
    assert (got === expv) else begin
      $display("[ERROR] %0t adr %0d read %h, expected %h", $time, adr, got, expv);
      if (adr == `VISION_ADR_COM) com_errs++;
      else bus_errs++;
    end
  endtask

  task automatic set_cfg(input channel_e c, input chan8_t lo, input chan8_t hi,
                         input bg_mode_e md, input logic cr);
    logic [31:0] r;
    wb_access(1'b1, `VISION_ADR_CHAN, 32'(c), r);
    wb_access(1'b1, `VISION_ADR_LOWER, 32'(lo), r);
    wb_access(1'b1, `VISION_ADR_UPPER, 32'(hi), r);
    wb_access(1'b1, `VISION_ADR_MODE, {29'b0, cr, md}, r);
    m_chan  = c;
    m_lo    = lo;
    m_hi    = hi;
    m_mode  = md;
    m_cross = cr;
  endtask

  task automatic rand_cfg(input bg_mode_e md, input channel_e c, input logic cr);
    chan8_t a, b;
    a = chan8_t'($urandom);
    b = chan8_t'($urandom);
    if (a <= b) set_cfg(c, a, b, md, cr);
    else set_cfg(c, b, a, md, cr); // keep lower <= upper
  endtask

  // one 32x16 window, near_com puts the current centre inside it
  task automatic run_frame(input logic near_com);
    int        x0, y0, sx, sy, n;
    rgb888_t   rgb;
    chan8_t    ch;
    logic      m, seen;
    out_beat_t e;
    x0 = near_com ? int'(exp_x) - int'($urandom_range(31)) : int'($urandom_range(1248));
    y0 = near_com ? int'(exp_y) - int'($urandom_range(15)) : int'($urandom_range(704));
    x0 = (x0 < 0) ? 0 : (x0 > `VISION_HRES - 32) ? `VISION_HRES - 32 : x0;
    y0 = (y0 < 0) ? 0 : (y0 > `VISION_VRES - 16) ? `VISION_VRES - 16 : y0;
    sx = 0;
    sy = 0;
    n  = 0;
    for (int i = 0; i < 512; i++) begin
      pix.valid  = 1'b1;
      pix.eof    = (i == 511);
      pix.hcount = hcount_t'(x0 + i % 32);
      pix.vcount = vcount_t'(y0 + i / 32);
      pix.pixel  = rgb565_t'($urandom);
      rgb = widen(pix.pixel);
      ch  = pick_chan(rgb, m_chan);
      m   = (ch >= m_lo) && (ch <= m_hi); // inclusive window
      case (m_mode)
        NORMAL:  e.pixel = rgb;
        GRAY:    e.pixel = {ch, ch, ch};
        MASK:    e.pixel = m ? 24'hffffff : 24'h000000;
        default: e.pixel = m ? 24'hff00ff : rgb;
      endcase
      if (m_cross && (pix.hcount == exp_x || pix.vcount == exp_y)) e.pixel = 24'hffffff;
      e.valid  = 1'b1;
      e.hcount = pix.hcount;
      e.vcount = pix.vcount;
      exp_q.push_back(e);
      due_q.push_back(cycles + `VISION_PIPE_LAT);
      if (m) begin
        sx += pix.hcount;
        sy += pix.vcount;
        n++;
      end
      tick();
    end
    pix  = '0;
    seen = 1'b0;
    for (int i = 0; i < ((n != 0) ? 100 : 80) && !seen; i++) begin
      tick();
      seen = com_valid;
    end
    if (n != 0) begin
      assert (seen) else begin
        $display("no com_valid_o pulse after a frame with %0d masked pixels", n);
        com_errs++;
      end
      exp_x = hcount_t'(sx / n); // truncated mean
      exp_y = vcount_t'(sy / n);
    end else begin
      assert (!seen) else begin
        $display("com_valid_o pulsed after a frame with no masked pixel");
        com_errs++;
      end
    end
    check_read(`VISION_ADR_COM, {6'b0, exp_y, 5'b0, exp_x});
  endtask

  initial begin
    logic [31:0] d, r;
    logic [31:0] fmask [4];
    fmask = '{32'h3, 32'hff, 32'hff, 32'h7}; // field widths of addresses 0 to 3
    void'($urandom(32'hd33a37cf));
    recent_reset = 1'b1;
    {wb_cyc, wb_stb, wb_we} = 3'b000;
    wb_adr  = 3'd0;
    wb_wdat = 32'h0;
    pix     = '0;
    set_cfg_model: begin
      m_chan  = RED;
      m_lo    = 8'd0;
      m_hi    = 8'd0;
      m_mode  = NORMAL;
      m_cross = 1'b0;
      exp_x   = '0;
      exp_y   = '0;
    end
    repeat (2) tick();
    recent_reset = 1'b0;
    tick();
    assert (!out.valid && !wb_ack && !com_valid) else begin
      $display("outputs active after reset");
      pix_errs++;
    end
    for (int a = 0; a < 5; a++) check_read(3'(a), 32'h0); // config and centre start at zero
    for (int k = 0; k < 3; k++) begin
      for (int a = 0; a < 4; a++) begin
        d = $urandom;
        wb_access(1'b1, 3'(a), d, r);
        check_read(3'(a), d & fmask[a]);
      end
    end
    wb_access(1'b1, `VISION_ADR_COM, $urandom, r); // read only, no effect
    check_read(`VISION_ADR_COM, 32'h0);
    for (int a = 5; a < 8; a++) check_read(3'(a), 32'h0);
    set_cfg(RED, 8'd0, 8'd127, NORMAL, 1'b0);
    run_frame(1'b0);
    set_cfg(LUMA, 8'd64, 8'd200, NORMAL, 1'b0);
    run_frame(1'b0);
    for (int md = 1; md < 4; md++) begin
      for (int c = 0; c < 4; c++) begin
        rand_cfg(bg_mode_e'(md), channel_e'(c), 1'b0);
        run_frame(1'b0);
      end
    end
    repeat (4) begin
      rand_cfg(bg_mode_e'($urandom_range(3)), channel_e'($urandom_range(3)), 1'b1);
      run_frame(1'b1);
    end
    set_cfg(GREEN, 8'd200, 8'd100, MASK, 1'b1); // empty window, nothing masked
    run_frame(1'b1);
    repeat (8) tick();
    assert (exp_q.size() == 0) else begin
      $display("%0d expected output beats still pending at the end", exp_q.size());
      pix_errs++;
    end
    $display("errors: bus %0d, pixel %0d, centre %0d", bus_errs, pix_errs, com_errs);
    if (bus_errs + pix_errs + com_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
